// File: include/mipsCore_config.svh
`ifndef MIPSCORE_CONFIG_SVH
`define MIPSCORE_CONFIG_SVH

// datapath and address width
`define DATA_W 32
`define REG_CNT 32

// first fetch after reset
`define RESET_PC 32'h0000_0000

// operand sources for the execute stage
`define FWD_REG 2'd0
`define FWD_MEM 2'd1
`define FWD_WB 2'd2

`endif

// File: hdl/mipsCorePkg.sv
`default_nettype none
`include "mipsCore_config.svh"

package mipsCorePkg;

    // R-format view of an instruction word
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instrT;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0, // zero so that a bubble adds
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_LUI = 4'd7
    } aluOpT;

    // all zero is a no-op
    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  aluSrcImm;
        logic  signExt;
        logic  regDstRd;
        logic  isBranch;
        logic  branchNe;
        logic  isJump;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        logic [`DATA_W-1:0] pc;
        logic [`DATA_W-1:0] instr;
    } ifIdT;

    typedef struct packed {
        logic [`DATA_W-1:0] pc;
        ctrlT               ctrl;
        logic [4:0]         rs;
        logic [4:0]         rt;
        logic [4:0]         dst;
        logic [`DATA_W-1:0] opA; // regfile values, before forwarding
        logic [`DATA_W-1:0] opB;
        logic [`DATA_W-1:0] imm;
        logic [4:0]         shamt;
    } idExT;

    typedef struct packed {
        logic [`DATA_W-1:0] pc;
        ctrlT               ctrl;
        logic [4:0]         dst;
        logic [`DATA_W-1:0] aluRes;
        logic [`DATA_W-1:0] storeData;
    } exMemT;

    typedef struct packed {
        logic [`DATA_W-1:0] pc;
        logic               regWrite;
        logic [4:0]         dst;
        logic [`DATA_W-1:0] result;
    } memWbT;

    // debug writeback record
    typedef struct packed {
        logic [`DATA_W-1:0] pc;
        logic               wen;
        logic [4:0]         wnum;
        logic [`DATA_W-1:0] wdata;
    } retireT;

    typedef struct packed {
        logic [`DATA_W-1:0] addr;
        logic [`DATA_W-1:0] data;
    } storeT;

endpackage

`default_nettype wire

// File: hdl/instrDecoder.sv
`timescale 1ns/100ps
`default_nettype none
`include "mipsCore_config.svh"

module instrDecoder (
    input  wire logic [`DATA_W-1:0] instr_i,
    output mipsCorePkg::ctrlT       ctrl_o,
    output logic [4:0]              rs_o,
    output logic [4:0]              rt_o,
    output logic [4:0]              dst_o,
    output logic [`DATA_W-1:0]      imm_o
);
    import mipsCorePkg::*;

    instrT fields;
    ctrlT  ctrl;

    assign fields = instr_i;
    assign rs_o = fields.rs;
    assign rt_o = fields.rt;
    assign dst_o = ctrl.regDstRd ? fields.rd : fields.rt;
    assign imm_o = ctrl.signExt ? {{(`DATA_W-16){instr_i[15]}}, instr_i[15:0]}
                                : {{(`DATA_W-16){1'b0}}, instr_i[15:0]};

    always_comb begin
        ctrl = '0;
        case (fields.opcode)
            6'h00: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDstRd = 1'b1;
                case (fields.funct)
                    6'h21: ctrl.aluOp = ALU_ADD; // addu
                    6'h23: ctrl.aluOp = ALU_SUB; // subu
                    6'h24: ctrl.aluOp = ALU_AND;
                    6'h25: ctrl.aluOp = ALU_OR;
                    6'h26: ctrl.aluOp = ALU_XOR;
                    6'h2a: ctrl.aluOp = ALU_SLT;
                    6'h00: ctrl.aluOp = ALU_SLL;
                    default: ctrl = '0;
                endcase
            end
            6'h09: begin // addiu
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.signExt = 1'b1;
            end
            6'h0c, 6'h0d, 6'h0f: begin // andi, ori, lui take a zero-extended imm
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = (fields.opcode == 6'h0c) ? ALU_AND :
                             (fields.opcode == 6'h0d) ? ALU_OR : ALU_LUI;
            end
            6'h23, 6'h2b: begin // lw, sw
                ctrl.regWrite = (fields.opcode == 6'h23);
                ctrl.memRead = (fields.opcode == 6'h23);
                ctrl.memWrite = (fields.opcode == 6'h2b);
                ctrl.aluSrcImm = 1'b1;
                ctrl.signExt = 1'b1;
            end
            6'h04, 6'h05: begin // beq, bne compare in the alu
                ctrl.isBranch = 1'b1;
                ctrl.branchNe = fields.opcode[0];
                ctrl.signExt = 1'b1;
                ctrl.aluOp = ALU_SUB;
            end
            6'h02: ctrl.isJump = 1'b1;
            default: ctrl = '0;
        endcase
    end

    // writing r0 changes nothing, so it becomes a bubble
    assign ctrl_o = (ctrl.regWrite && dst_o == '0) ? '0 : ctrl;

endmodule

`default_nettype wire

// File: hdl/regFile.sv
`timescale 1ns/100ps
`default_nettype none
`include "mipsCore_config.svh"

module regFile (
    input  wire logic               clk,
    input  wire logic               rst_i,
    input  wire logic [4:0]         raddrA_i,
    input  wire logic [4:0]         raddrB_i,
    output logic [`DATA_W-1:0]      rdataA_o,
    output logic [`DATA_W-1:0]      rdataB_o,
    input  wire logic               we_i,
    input  wire logic [4:0]         waddr_i,
    input  wire logic [`DATA_W-1:0] wdata_i
);
    logic [`DATA_W-1:0] regs [`REG_CNT];
    logic               wrEn;

    assign wrEn = we_i && (waddr_i != '0); // r0 stays zero

    always_ff @(posedge clk) begin
        if (rst_i) begin
            regs <= '{default: '0};
        end else if (wrEn) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // writeback in the same cycle wins over the stored value
    assign rdataA_o = (wrEn && waddr_i == raddrA_i) ? wdata_i : regs[raddrA_i];
    assign rdataB_o = (wrEn && waddr_i == raddrB_i) ? wdata_i : regs[raddrB_i];

endmodule

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/100ps
`default_nettype none
`include "mipsCore_config.svh"

module alu (
    input  wire logic                clk,
    input  wire logic                rst_i,
    input  wire mipsCorePkg::aluOpT  op_i,
    input  wire logic [`DATA_W-1:0]  a_i,
    input  wire logic [`DATA_W-1:0]  b_i,
    input  wire logic [4:0]          shamt_i,
    output logic [`DATA_W-1:0]       result_o,
    output logic                     equal_o
);
    import mipsCorePkg::*;

    always_comb begin
        case (op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_XOR: result_o = a_i ^ b_i;
            ALU_SLT: result_o = {{(`DATA_W-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            ALU_SLL: result_o = b_i << shamt_i; // sll shifts rt
            ALU_LUI: result_o = {b_i[15:0], 16'b0};
            default: result_o = '0;
        endcase
    end

    assign equal_o = (a_i == b_i); // branch compare

    // stage registers are cleared by reset, so the opcode is always defined afterwards
    opKnown: assert property (@(posedge clk) disable iff (rst_i) !$isunknown(op_i))
        else $error("alu op is unknown");

endmodule

`default_nettype wire

// File: hdl/stageReg.sv
`timescale 1ns/100ps
`default_nettype none

module stageReg #(
    parameter type payloadT = logic [31:0]
) (
    input  wire logic    clk,
    input  wire logic    rst_i,
    input  wire logic    stall_i,
    input  wire logic    flush_i,
    input  wire payloadT d_i,
    output payloadT      q_o
);

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            q_o <= '0; // bubble
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/hazardCtrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "mipsCore_config.svh"

module hazardCtrl (
    input  wire logic               clk,
    input  wire logic               rst_i,
    input  wire logic [4:0]         decRs_i,
    input  wire logic [4:0]         decRt_i,
    input  wire logic               decJump_i,
    input  wire mipsCorePkg::idExT  exStage_i,
    input  wire logic               branchTaken_i,
    input  wire mipsCorePkg::exMemT memStage_i,
    input  wire mipsCorePkg::memWbT wbStage_i,
    input  wire logic               dStall_i,
    output logic                    stallF_o,
    output logic                    stallD_o,
    output logic                    stallE_o,
    output logic                    stallM_o,
    output logic                    stallW_o,
    output logic                    flushD_o,
    output logic                    flushE_o,
    output logic                    flushM_o,
    output logic [1:0]              fwdA_o,
    output logic [1:0]              fwdB_o
);
    import mipsCorePkg::*;

    logic loadUse;

    // newest producer first
    function automatic logic [1:0] fwdSel(
        input logic [4:0] src,
        input exMemT      m,
        input memWbT      w
    );
        if (m.ctrl.regWrite && m.dst != '0 && m.dst == src) begin
            return `FWD_MEM;
        end
        if (w.regWrite && w.dst != '0 && w.dst == src) begin
            return `FWD_WB;
        end
        return `FWD_REG;
    endfunction

    assign fwdA_o = fwdSel(exStage_i.rs, memStage_i, wbStage_i);
    assign fwdB_o = fwdSel(exStage_i.rt, memStage_i, wbStage_i);

    // conservative since rt counts even for instructions that ignore it
    assign loadUse = exStage_i.ctrl.memRead && exStage_i.dst != '0
                     && (exStage_i.dst == decRs_i || exStage_i.dst == decRt_i);

    always_comb begin
        stallF_o = 1'b0;
        stallD_o = 1'b0;
        stallE_o = 1'b0;
        stallM_o = 1'b0;
        stallW_o = 1'b0;
        flushD_o = 1'b0;
        flushE_o = 1'b0;
        flushM_o = 1'b0; // nothing is squashed past execute
        if (dStall_i) begin // freeze everything
            stallF_o = 1'b1;
            stallD_o = 1'b1;
            stallE_o = 1'b1;
            stallM_o = 1'b1;
            stallW_o = 1'b1;
        end else if (branchTaken_i) begin
            flushD_o = 1'b1; // kill wrong-path fetch and decode
            flushE_o = 1'b1;
        end else if (loadUse) begin
            stallF_o = 1'b1;
            stallD_o = 1'b1;
            flushE_o = 1'b1; // bubble behind the load
        end else if (decJump_i) begin
            flushD_o = 1'b1;
        end
    end

    loadUseOnce: assert property (@(posedge clk) disable iff (rst_i)
        (loadUse && !dStall_i) |=> !loadUse)
        else $error("load-use stall held longer than one cycle");

endmodule

`default_nettype wire

// File: hdl/datapath.sv
`timescale 1ns/100ps
`default_nettype none
`include "mipsCore_config.svh"

module datapath (
    input  wire logic               clk,
    input  wire logic               rst_i,
    // instruction port
    output logic [`DATA_W-1:0]      pcF_o,
    input  wire logic [`DATA_W-1:0] instrF_i,
    // data port
    output logic                    memEn_o,
    output logic                    memWe_o,
    output logic [`DATA_W-1:0]      memAddr_o,
    output logic [`DATA_W-1:0]      memWdata_o,
    input  wire logic [`DATA_W-1:0] memRdata_i,
    output mipsCorePkg::retireT     retire_o,
    // from hazardCtrl
    input  wire logic               stallF_i,
    input  wire logic               stallD_i,
    input  wire logic               stallE_i,
    input  wire logic               stallM_i,
    input  wire logic               stallW_i,
    input  wire logic               flushD_i,
    input  wire logic               flushE_i,
    input  wire logic               flushM_i,
    input  wire logic [1:0]         fwdA_i,
    input  wire logic [1:0]         fwdB_i,
    // to hazardCtrl
    output logic [4:0]              decRs_o,
    output logic [4:0]              decRt_o,
    output logic                    decJump_o,
    output mipsCorePkg::idExT       exStage_o,
    output logic                    branchTaken_o,
    output mipsCorePkg::exMemT      memStage_o,
    output mipsCorePkg::memWbT      wbStage_o
);
    import mipsCorePkg::*;

    ifIdT               ifIdD;
    ifIdT               ifIdQ;
    idExT               idExD;
    idExT               exQ;
    exMemT              exMemD;
    exMemT              memQ;
    memWbT              memWbD;
    memWbT              wbQ;
    ctrlT               ctrlD;
    logic [4:0]         rsD;
    logic [4:0]         rtD;
    logic [4:0]         dstD;
    logic [`DATA_W-1:0] immD;
    logic [`DATA_W-1:0] rdataA;
    logic [`DATA_W-1:0] rdataB;
    logic [`DATA_W-1:0] pcNext;
    logic [`DATA_W-1:0] pcPlus4D;
    logic [`DATA_W-1:0] jumpTarget;
    logic [`DATA_W-1:0] branchTarget;
    logic [`DATA_W-1:0] srcA;
    logic [`DATA_W-1:0] srcB;
    logic [`DATA_W-1:0] aluResult;
    logic               aluEqual;
    logic               branchTaken;
    logic [`DATA_W-1:0] resultM;

    // fetch where the branch redirect beats the jump
    assign pcNext = branchTaken ? branchTarget :
                    ctrlD.isJump ? jumpTarget : pcF_o + 4;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pcF_o <= `RESET_PC;
        end else if (!stallF_i) begin
            pcF_o <= pcNext;
        end
    end

    assign ifIdD = '{pc: pcF_o, instr: instrF_i};
    stageReg #(.payloadT(ifIdT)) ifIdReg (
        .clk(clk), .rst_i(rst_i), .stall_i(stallD_i), .flush_i(flushD_i),
        .d_i(ifIdD), .q_o(ifIdQ)
    );

    // decode
    instrDecoder decoder (
        .instr_i(ifIdQ.instr), .ctrl_o(ctrlD), .rs_o(rsD), .rt_o(rtD),
        .dst_o(dstD), .imm_o(immD)
    );

    regFile rf (
        .clk(clk), .rst_i(rst_i),
        .raddrA_i(rsD), .raddrB_i(rtD), .rdataA_o(rdataA), .rdataB_o(rdataB),
        .we_i(wbQ.regWrite && !stallW_i), .waddr_i(wbQ.dst), .wdata_i(wbQ.result)
    );

    assign pcPlus4D = ifIdQ.pc + 4;
    assign jumpTarget = {pcPlus4D[`DATA_W-1 -: 4], ifIdQ.instr[25:0], 2'b00};

    assign idExD = '{pc: ifIdQ.pc, ctrl: ctrlD, rs: rsD, rt: rtD, dst: dstD,
                     opA: rdataA, opB: rdataB, imm: immD, shamt: ifIdQ.instr[10:6]};
    stageReg #(.payloadT(idExT)) idExReg (
        .clk(clk), .rst_i(rst_i), .stall_i(stallE_i), .flush_i(flushE_i),
        .d_i(idExD), .q_o(exQ)
    );

    // execute with operands forwarded from memory and writeback
    assign srcA = (fwdA_i == `FWD_REG) ? exQ.opA :
                  (fwdA_i == `FWD_MEM) ? resultM : wbQ.result;
    assign srcB = (fwdB_i == `FWD_REG) ? exQ.opB :
                  (fwdB_i == `FWD_MEM) ? resultM : wbQ.result;

    alu alu0 (
        .clk(clk), .rst_i(rst_i), .op_i(exQ.ctrl.aluOp),
        .a_i(srcA), .b_i(exQ.ctrl.aluSrcImm ? exQ.imm : srcB), .shamt_i(exQ.shamt),
        .result_o(aluResult), .equal_o(aluEqual)
    );

    assign branchTaken = exQ.ctrl.isBranch && (aluEqual ^ exQ.ctrl.branchNe);
    assign branchTarget = exQ.pc + 4 + {exQ.imm[`DATA_W-3:0], 2'b00};

    assign exMemD = '{pc: exQ.pc, ctrl: exQ.ctrl, dst: exQ.dst,
                      aluRes: aluResult, storeData: srcB};
    stageReg #(.payloadT(exMemT)) exMemReg (
        .clk(clk), .rst_i(rst_i), .stall_i(stallM_i), .flush_i(flushM_i),
        .d_i(exMemD), .q_o(memQ)
    );

    // memory request held by stallM while dStall is high
    assign memEn_o = memQ.ctrl.memRead || memQ.ctrl.memWrite;
    assign memWe_o = memQ.ctrl.memWrite;
    assign memAddr_o = memQ.aluRes;
    assign memWdata_o = memQ.storeData;
    assign resultM = memQ.ctrl.memRead ? memRdata_i : memQ.aluRes;

    assign memWbD = '{pc: memQ.pc, regWrite: memQ.ctrl.regWrite, dst: memQ.dst,
                      result: resultM};
    stageReg #(.payloadT(memWbT)) memWbReg (
        .clk(clk), .rst_i(rst_i), .stall_i(stallW_i), .flush_i(1'b0),
        .d_i(memWbD), .q_o(wbQ)
    );

    // writeback retires once on the cycle it leaves the pipe
    assign retire_o = '{pc: wbQ.pc, wen: wbQ.regWrite && wbQ.dst != '0 && !stallW_i,
                        wnum: wbQ.dst, wdata: wbQ.result};

    assign decRs_o = rsD;
    assign decRt_o = rtD;
    assign decJump_o = ctrlD.isJump;
    assign exStage_o = exQ;
    assign branchTaken_o = branchTaken;
    assign memStage_o = memQ;
    assign wbStage_o = wbQ;

    memHeld: assert property (@(posedge clk) disable iff (rst_i)
        (memEn_o && stallM_i) |=> (memEn_o && $stable({memWe_o, memAddr_o, memWdata_o})))
        else $error("memory request changed while stalled");

endmodule

`default_nettype wire

// File: hdl/mipsCore.sv
`timescale 1ns/100ps
`default_nettype none
`include "mipsCore_config.svh"

module mipsCore (
    input  wire logic               clk,
    input  wire logic               rst_i,
    output logic [`DATA_W-1:0]      pcF_o,
    input  wire logic [`DATA_W-1:0] instrF_i,
    output logic                    memEn_o,
    output logic                    memWe_o,
    output logic [`DATA_W-1:0]      memAddr_o,
    output logic [`DATA_W-1:0]      memWdata_o,
    input  wire logic [`DATA_W-1:0] memRdata_i,
    input  wire logic               dStall_i,
    output mipsCorePkg::retireT     retire_o
);
    import mipsCorePkg::*;

    logic       stallF;
    logic       stallD;
    logic       stallE;
    logic       stallM;
    logic       stallW;
    logic       flushD;
    logic       flushE;
    logic       flushM;
    logic [1:0] fwdA;
    logic [1:0] fwdB;
    logic [4:0] decRs;
    logic [4:0] decRt;
    logic       decJump;
    idExT       exStage;
    logic       branchTaken;
    exMemT      memStage;
    memWbT      wbStage;

    datapath datapath_inst (
        .clk(clk), .rst_i(rst_i),
        .pcF_o(pcF_o), .instrF_i(instrF_i),
        .memEn_o(memEn_o), .memWe_o(memWe_o), .memAddr_o(memAddr_o),
        .memWdata_o(memWdata_o), .memRdata_i(memRdata_i), .retire_o(retire_o),
        .stallF_i(stallF), .stallD_i(stallD), .stallE_i(stallE),
        .stallM_i(stallM), .stallW_i(stallW),
        .flushD_i(flushD), .flushE_i(flushE), .flushM_i(flushM),
        .fwdA_i(fwdA), .fwdB_i(fwdB),
        .decRs_o(decRs), .decRt_o(decRt), .decJump_o(decJump),
        .exStage_o(exStage), .branchTaken_o(branchTaken),
        .memStage_o(memStage), .wbStage_o(wbStage)
    );

    hazardCtrl hazardCtrl_inst (
        .clk(clk), .rst_i(rst_i),
        .decRs_i(decRs), .decRt_i(decRt), .decJump_i(decJump),
        .exStage_i(exStage), .branchTaken_i(branchTaken),
        .memStage_i(memStage), .wbStage_i(wbStage), .dStall_i(dStall_i),
        .stallF_o(stallF), .stallD_o(stallD), .stallE_o(stallE),
        .stallM_o(stallM), .stallW_o(stallW),
        .flushD_o(flushD), .flushE_o(flushE), .flushM_o(flushM),
        .fwdA_o(fwdA), .fwdB_o(fwdB)
    );

endmodule

`default_nettype wire

// File: verification/mipsCoreTb.sv
`timescale 1ns/100ps
`default_nettype none
`include "mipsCore_config.svh"

module mipsCoreTb;
    import mipsCorePkg::*;

    localparam int PROG_LEN = 64;       // last of these words jumps to itself
    localparam int IMEM_WORDS = 128;
    localparam int DMEM_WORDS = 64;     // lw/sw window starting at address 0
    localparam int TIMEOUT = 20000;     // cycles per wait loop
    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_CYCLES = 16;   // watch for extra records after the last one

    logic               clk;
    logic               rst_i;
    logic [`DATA_W-1:0] pcF_o;
    logic [`DATA_W-1:0] instrF_i;
    logic               memEn_o;
    logic               memWe_o;
    logic [`DATA_W-1:0] memAddr_o;
    logic [`DATA_W-1:0] memWdata_o;
    logic [`DATA_W-1:0] memRdata_i;
    logic               dStall_i;
    retireT             retire_o;

    logic [`DATA_W-1:0] imem [IMEM_WORDS];
    logic [`DATA_W-1:0] dmem [DMEM_WORDS];
    retireT             retireQ [$];    // expected records in program order
    storeT              storeQ [$];
    integer             seed = 18802;
    logic               rstHold;
    logic               stallOn;
    logic               hung;
    int                 tests;
    int                 failedTests;
    int                 checks;
    int                 errors;

    mipsCore mipsCore_inst (
        .clk(clk), .rst_i(rst_i),
        .pcF_o(pcF_o), .instrF_i(instrF_i),
        .memEn_o(memEn_o), .memWe_o(memWe_o), .memAddr_o(memAddr_o),
        .memWdata_o(memWdata_o), .memRdata_i(memRdata_i), .dStall_i(dStall_i),
        .retire_o(retire_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int unsigned randBelow(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [4:0] randReg();
        return 5'(1 + randBelow(7)); // r1..r7
    endfunction

    // initial data word from the whole byte address
    function automatic logic [`DATA_W-1:0] fillWord(input int idx);
        logic [`DATA_W-1:0] addr;
        addr = idx * 4;
        return (addr * 32'h9E37_79B1) ^ {addr[15:0], ~addr[15:0]};
    endfunction

    task automatic initDmem();
        int i;
        for (i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = fillWord(i);
        end
    endtask

    task automatic checkRetire(input retireT got);
        retireT exp;
        checks++;
        if (retireQ.size() == 0) begin
            errors++;
            $display("Fail %0t: unexpected retire pc %h r%0d=%h", $time,
                     got.pc, got.wnum, got.wdata);
        end else begin
            exp = retireQ.pop_front();
            if (got !== exp) begin
                errors++;
                $display("Fail %0t: retire expected pc %h r%0d=%h, got pc %h r%0d=%h",
                         $time, exp.pc, exp.wnum, exp.wdata, got.pc, got.wnum, got.wdata);
            end
        end
    endtask

    task automatic checkStore(input storeT got);
        storeT exp;
        checks++;
        if (storeQ.size() == 0) begin
            errors++;
            $display("Fail %0t: unexpected store [%h]=%h", $time, got.addr, got.data);
        end else begin
            exp = storeQ.pop_front();
            if (got !== exp) begin
                errors++;
                $display("Fail %0t: store expected [%h]=%h, got [%h]=%h", $time,
                         exp.addr, exp.data, got.addr, got.data);
            end
        end
    endtask

    task automatic checkReset(input retireT r, input logic en, input logic [`DATA_W-1:0] pc);
        checks++;
        if (r.wen !== 1'b0 || en !== 1'b0 || pc !== `RESET_PC) begin
            errors++;
            $display("Fail %0t: in reset wen=%b memEn=%b pc=%h, expected 0 0 %h", $time,
                     r.wen, en, pc, `RESET_PC);
        end
    endtask

    // drive on the falling edge and sample after the inputs settle
    task automatic stepCycle(input bit check);
        storeT st;
        @(negedge clk);
        rst_i = rstHold;
        instrF_i = (pcF_o[`DATA_W-1:9] == '0) ? imem[pcF_o[8:2]] : '0;
        memRdata_i = dmem[memAddr_o[7:2]];
        dStall_i = stallOn && !rstHold && (randBelow(4) == 0); // about 25% high
        #2;
        if (check) begin
            if (retire_o.wen) begin
                checkRetire(retire_o);
            end
            if (memEn_o && memWe_o && !dStall_i) begin // write lands on the next edge
                st.addr = memAddr_o;
                st.data = memWdata_o;
                dmem[memAddr_o[7:2]] = memWdata_o;
                checkStore(st);
            end
        end
    endtask

    task automatic resetCore();
        int i;
        rstHold = 1'b1;
        for (i = 0; i < RESET_CYCLES; i++) begin
            stepCycle(1'b0);
            if (i > 0) begin
                checkReset(retire_o, memEn_o, pcF_o);
            end
        end
        rstHold = 1'b0;
    endtask

    task automatic genProgram(input bit useMem, input bit useBranch);
        int          i;
        int          span;
        int          tgt;
        int unsigned pick;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [4:0]  prevLoad;
        logic [15:0] imm;
        logic [15:0] off;
        logic [31:0] ins;
        for (i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = '0;
        end
        prevLoad = '0;
        for (i = 0; i < PROG_LEN - 1; i++) begin
            rs = randReg();
            rt = randReg();
            rd = randReg();
            sh = 5'(randBelow(32));
            imm = 16'($random(seed));
            off = {8'h00, 6'(randBelow(DMEM_WORDS)), 2'b00};
            if (prevLoad != '0) begin
                rs = prevLoad; // consume the load right away
            end
            prevLoad = '0;
            pick = randBelow(10);
            if (useBranch && pick >= 8) begin
                span = PROG_LEN - 1 - i;
                if (span > 6) begin
                    span = 6;
                end
                tgt = i + 1 + int'(randBelow(span)); // forward only
                pick = randBelow(3);
                if (pick == 2) begin
                    ins = {6'h02, 26'(tgt)};
                end else begin
                    if (randBelow(4) == 0) begin
                        rt = rs; // beq taken more often
                    end
                    ins = {(pick == 0) ? 6'h04 : 6'h05, rs, rt, 16'(tgt - i - 1)};
                end
            end else if (useMem && pick >= 6) begin
                if (randBelow(2) == 0) begin
                    ins = {6'h23, 5'd0, rd, off}; // lw
                    prevLoad = rd;
                end else begin
                    ins = {6'h2b, 5'd0, rt, off}; // sw
                end
            end else begin
                case (randBelow(11))
                    0: ins = {6'h00, rs, rt, rd, 5'd0, 6'h21};
                    1: ins = {6'h00, rs, rt, rd, 5'd0, 6'h23};
                    2: ins = {6'h00, rs, rt, rd, 5'd0, 6'h24};
                    3: ins = {6'h00, rs, rt, rd, 5'd0, 6'h25};
                    4: ins = {6'h00, rs, rt, rd, 5'd0, 6'h26};
                    5: ins = {6'h00, rs, rt, rd, 5'd0, 6'h2a};
                    6: ins = {6'h00, 5'd0, rt, rd, sh, 6'h00}; // sll
                    7: ins = {6'h09, rs, rd, imm};
                    8: ins = {6'h0c, rs, rd, imm};
                    9: ins = {6'h0d, rs, rd, imm};
                    default: ins = {6'h0f, 5'd0, rd, imm}; // lui
                endcase
            end
            imem[i] = ins;
        end
        imem[PROG_LEN - 1] = {6'h02, 26'(PROG_LEN - 1)}; // park here
    endtask

    // ISA interpreter without delay slots that fills the expected queues
    task automatic runModel();
        logic [`DATA_W-1:0] regs [`REG_CNT];
        logic [`DATA_W-1:0] mem [DMEM_WORDS];
        logic [`DATA_W-1:0] pc;
        logic [`DATA_W-1:0] nextPc;
        logic [`DATA_W-1:0] ins;
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        logic [`DATA_W-1:0] sext;
        logic [`DATA_W-1:0] zext;
        logic [`DATA_W-1:0] ea;
        logic [`DATA_W-1:0] res;
        logic [4:0]         dst;
        logic               wr;
        retireT             rec;
        storeT              st;
        int                 i;
        int                 steps;
        retireQ.delete();
        storeQ.delete();
        for (i = 0; i < `REG_CNT; i++) begin
            regs[i] = '0;
        end
        for (i = 0; i < DMEM_WORDS; i++) begin
            mem[i] = fillWord(i);
        end
        pc = `RESET_PC;
        steps = 0;
        while (pc != (PROG_LEN - 1) * 4 && steps < IMEM_WORDS) begin
            ins = imem[pc[8:2]];
            a = regs[ins[25:21]];
            b = regs[ins[20:16]];
            sext = {{16{ins[15]}}, ins[15:0]};
            zext = {16'h0000, ins[15:0]};
            ea = a + sext;
            dst = ins[20:16];
            wr = 1'b1;
            res = '0;
            nextPc = pc + 4;
            case (ins[31:26])
                6'h00: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        6'h21: res = a + b;
                        6'h23: res = a - b;
                        6'h24: res = a & b;
                        6'h25: res = a | b;
                        6'h26: res = a ^ b;
                        6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        6'h00: res = b << ins[10:6];
                        default: wr = 1'b0;
                    endcase
                end
                6'h09: res = a + sext;
                6'h0c: res = a & zext;
                6'h0d: res = a | zext;
                6'h0f: res = {ins[15:0], 16'h0000};
                6'h23: res = mem[ea[7:2]];
                6'h2b: begin
                    wr = 1'b0;
                    st.addr = ea;
                    st.data = b;
                    storeQ.push_back(st);
                    mem[ea[7:2]] = b;
                end
                6'h04, 6'h05: begin
                    wr = 1'b0;
                    if ((a == b) != ins[26]) begin // bne has opcode bit 0 set
                        nextPc = pc + 4 + (sext << 2);
                    end
                end
                6'h02: begin
                    wr = 1'b0;
                    nextPc = {nextPc[31:28], ins[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != '0) begin
                regs[dst] = res;
                rec.pc = pc;
                rec.wen = 1'b1;
                rec.wnum = dst;
                rec.wdata = res;
                retireQ.push_back(rec);
            end
            pc = nextPc;
            steps++;
        end
    endtask

    task automatic finishTest(input string name, input int errBefore);
        tests++;
        if (errors > errBefore) begin
            failedTests++;
            $display("test %s: %0d errors", name, errors - errBefore);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic resetTest();
        int errBefore;
        int i;
        errBefore = errors;
        for (i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = '0;
        end
        initDmem();
        stallOn = 1'b0;
        resetCore();
        finishTest("reset", errBefore);
    endtask

    task automatic runProgram(input string name, input bit useMem, input bit useBranch,
                              input bit useStall);
        int errBefore;
        int cyc;
        int expRetires;
        int expStores;
        if (hung) begin
            return;
        end
        errBefore = errors;
        genProgram(useMem, useBranch);
        runModel();
        expRetires = retireQ.size();
        expStores = storeQ.size();
        initDmem();
        stallOn = 1'b0;
        resetCore();
        stallOn = useStall;
        cyc = 0;
        while ((retireQ.size() > 0 || storeQ.size() > 0) && cyc < TIMEOUT) begin
            stepCycle(1'b1);
            cyc++;
        end
        if (retireQ.size() > 0 || storeQ.size() > 0) begin
            hung = 1'b1;
            tests++;
            failedTests++;
            $display("test %s: core stopped retiring, %0d retires and %0d stores still missing",
                     name, retireQ.size(), storeQ.size());
        end else begin
            for (cyc = 0; cyc < DRAIN_CYCLES; cyc++) begin
                stepCycle(1'b1);
            end
            finishTest($sformatf("%s (%0d retires, %0d stores)", name, expRetires, expStores),
                       errBefore);
        end
        stallOn = 1'b0;
    endtask

    initial begin
        rst_i = 1'b1;
        instrF_i = '0;
        memRdata_i = '0;
        dStall_i = 1'b0;
        rstHold = 1'b1;
        stallOn = 1'b0;
        hung = 1'b0;
        tests = 0;
        failedTests = 0;
        checks = 0;
        errors = 0;
        resetTest();
        runProgram("alu", 1'b0, 1'b0, 1'b0);
        runProgram("loadStore", 1'b1, 1'b0, 1'b0);
        runProgram("branch", 1'b0, 1'b1, 1'b0);
        runProgram("mixed", 1'b1, 1'b1, 1'b0);
        runProgram("dStall", 1'b1, 1'b1, 1'b1);
        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failedTests,
                 checks, errors);
        if (!hung && errors == 0 && failedTests == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mipsCore.f
+incdir+include
hdl/mipsCorePkg.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/alu.sv
hdl/stageReg.sv
hdl/hazardCtrl.sv
hdl/datapath.sv
hdl/mipsCore.sv
verification/mipsCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the mipsCore testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f mipsCore.f --top-module mipsCoreTb -Mdir obj_dir
./obj_dir/VmipsCoreTb | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
